// File: flist.f
verilog/pci_pkg.sv
verilog/pci_pad_ring.sv
verilog/pci_target_fsm.sv
verilog/pci_parity.sv
verilog/wb_master_port.sv
verilog/pci_wb_bridge.sv
tests/bridge_checker.sv
tests/tb_pci_wb_bridge.sv

// File: tests/bridge_checker.sv
// ========================================
// watches the bridge pins, keeps a shadow memory
// and compares every PCI and Wishbone transaction.
// ========================================
`timescale 1ns/10ps

module bridge_checker #(
   parameter logic [31:0] BAR_BASE      = 32'h8000_0000,
   parameter int          BAR_SIZE_LOG2 = 12
) (
   input  logic        pci_clk_i,
   input  logic        reset_i,
   input  logic        pci_frame_n_i,
   input  logic [3:0]  pci_cbe_n_i,
   input  logic [31:0] pci_ad_i,
   input  logic        pci_par_i,
   input  logic        pci_devsel_n_i,
   input  logic        pci_trdy_n_i,
   input  logic        pci_stop_n_i,
   input  logic        pci_perr_n_i,
   input  logic        pci_inta_n_i,
   input  logic        wb_int_i,
   input  logic [31:0] wbm_adr_i,
   input  logic [31:0] wbm_wdat_i,
   input  logic [3:0]  wbm_sel_i,
   input  logic        wbm_we_i,
   input  logic        wbm_cyc_i,
   input  logic        wbm_stb_i,
   input  logic        wbm_ack_i,
   input  logic        wbm_err_i,
   input  logic        wbm_rty_i,
   output int          errors_o
);

   logic [31:0] shadow [0:1023];
   logic        frame_d;
   logic        reset_d;
   logic        in_txn;
   logic        claim_exp;
   logic        seen_devsel;
   logic        seen_cyc;
   logic        is_write;
   logic [31:0] t_addr;
   logic [31:0] t_data;
   logic [3:0]  t_cmd;
   logic [3:0]  t_be;
   int          cnt;
   int          kind;                          // 0 none, 1 ack, 2 err, 3 rty.
   logic        rd_par_pend;
   logic        rd_par_exp;
   logic        wr_par_pend;
   logic        wr_par_exp;
   logic        perr_exp;
   int          perr_win;
   int          perr_seen;

   function automatic logic even_parity(input logic [31:0] ad, input logic [3:0] cbe);
      return ^{ad, cbe};
   endfunction

   function automatic logic [31:0] expected_read(input logic [31:0] addr);
      return shadow[addr[11:2]];
   endfunction

   task automatic report_mismatch(input string msg);
      errors_o++;
      $display("[FAIL] %0t: %s", $time, msg);
   endtask

   initial begin
      errors_o = 0;
      in_txn = 0;
      rd_par_pend = 0;
      wr_par_pend = 0;
      perr_win = 0;
      for (int i = 0; i < 1024; i++) begin
         shadow[i] = 32'h5A00_0000 ^ (i * 32'h0001_0203);   // same fill as the memory model.
      end
   end

   always @(posedge pci_clk_i) begin
      frame_d <= pci_frame_n_i;
      reset_d <= reset_i;
      if (!reset_i) begin
         if (reset_d) begin
            if (pci_devsel_n_i !== 1'b1 || pci_trdy_n_i !== 1'b1 || pci_stop_n_i !== 1'b1 ||
                pci_perr_n_i !== 1'b1 || pci_par_i !== 1'b1 || pci_ad_i !== '1 || wbm_cyc_i)
               report_mismatch("pins not released after reset");
         end
         if (pci_inta_n_i !== (wb_int_i ? 1'b0 : 1'b1))
            report_mismatch("INTA# does not follow the interrupt");
         if (wbm_stb_i !== wbm_cyc_i)
            report_mismatch("Wishbone STB differs from CYC");
         if (rd_par_pend) begin
            rd_par_pend = 0;
            if (pci_par_i !== rd_par_exp)
               report_mismatch($sformatf("read PAR %b, expected %b", pci_par_i, rd_par_exp));
         end
         // PERR# must pulse once inside a short window after a bad write.
         if (wr_par_pend) begin
            wr_par_pend = 0;
            perr_exp = (pci_par_i !== wr_par_exp);
            perr_seen = 0;
            perr_win = 5;
         end else if (perr_win > 0) begin
            if (pci_perr_n_i === 1'b0) perr_seen++;
            perr_win--;
            if (perr_win == 0 && perr_seen != int'(perr_exp))
               report_mismatch($sformatf("%0d PERR# pulses, expected %0d", perr_seen, perr_exp));
         end else if (pci_perr_n_i === 1'b0) begin
            report_mismatch("PERR# low without a write parity error");
         end
         if (wbm_cyc_i && !in_txn)
            report_mismatch("Wishbone cycle outside a PCI transaction");
         if (pci_frame_n_i === 1'b0 && frame_d === 1'b1) begin
            in_txn = 1;
            cnt = 0;
            t_addr = pci_ad_i;
            t_cmd = pci_cbe_n_i;
            is_write = (t_cmd == 4'h7);
            claim_exp = ((t_addr >> BAR_SIZE_LOG2) == (BAR_BASE >> BAR_SIZE_LOG2)) &&
                        (t_cmd == 4'h6 || t_cmd == 4'h7);
            seen_devsel = 0;
            seen_cyc = 0;
            kind = 0;
         end else if (in_txn) begin
            cnt++;
            if (cnt == 1) begin
               t_be = pci_cbe_n_i;
               t_data = pci_ad_i;
            end
            if (pci_devsel_n_i === 1'b0 && !seen_devsel) begin
               seen_devsel = 1;
               if (!claim_exp) report_mismatch("DEVSEL# on an unclaimed access");
               else if (cnt != 3) report_mismatch($sformatf("DEVSEL# after %0d clocks", cnt));
            end
            if (wbm_cyc_i && !seen_cyc) begin
               seen_cyc = 1;
               if (!claim_exp) report_mismatch("Wishbone cycle for an unclaimed access");
               if (wbm_adr_i !== t_addr || wbm_we_i !== is_write || wbm_sel_i !== ~t_be)
                  report_mismatch($sformatf("wb adr %h we %b sel %h", wbm_adr_i, wbm_we_i,
                                            wbm_sel_i));
               if (is_write && wbm_wdat_i !== t_data)
                  report_mismatch($sformatf("wb data %h, expected %h", wbm_wdat_i, t_data));
            end
            if (wbm_cyc_i && (wbm_ack_i || wbm_err_i || wbm_rty_i) && kind == 0) begin
               if (wbm_err_i) begin
                  kind = 2;
               end else if (wbm_rty_i) begin
                  kind = 3;
               end else begin
                  kind = 1;
               end
            end
            if (pci_trdy_n_i === 1'b0 || pci_stop_n_i === 1'b0) begin
               in_txn = 0;
               case (kind)
                  1: begin
                     if (pci_trdy_n_i !== 1'b0 || pci_stop_n_i !== 1'b1) begin
                        report_mismatch("normal completion expected");
                     end else if (!is_write) begin
                        if (pci_ad_i !== expected_read(t_addr))
                           report_mismatch($sformatf("read %h at %h, expected %h", pci_ad_i,
                                                     t_addr, expected_read(t_addr)));
                        rd_par_pend = 1;
                        rd_par_exp = even_parity(pci_ad_i, pci_cbe_n_i);
                     end else begin
                        for (int b = 0; b < 4; b++) begin
                           if (!t_be[b]) shadow[t_addr[11:2]][8*b +: 8] = t_data[8*b +: 8];
                        end
                        wr_par_pend = 1;
                        wr_par_exp = even_parity(t_data, t_be);
                     end
                  end
                  2: begin
                     if (pci_stop_n_i !== 1'b0 || pci_devsel_n_i !== 1'b1 ||
                         pci_trdy_n_i !== 1'b1)
                        report_mismatch("target abort expected");
                  end
                  3: begin
                     if (pci_stop_n_i !== 1'b0 || pci_devsel_n_i !== 1'b0 ||
                         pci_trdy_n_i !== 1'b1)
                        report_mismatch("retry expected");
                  end
                  default: report_mismatch("target ended without a Wishbone response");
               endcase
            end else if (cnt == 5) begin
               if (!claim_exp) begin
                  in_txn = 0;
               end else if (!seen_devsel) begin
                  report_mismatch("no DEVSEL# on a claimed access");
               end
            end
         end
      end
   end

endmodule

// File: tests/tb_pci_wb_bridge.sv
// ========================================
// testbench for the bridge with a PCI master model,
// a Wishbone memory model and the test sequence.
// ========================================
`timescale 1ns/10ps

module tb_pci_wb_bridge;
   import pci_pkg::*;

   localparam logic [31:0] BAR      = 32'h8000_0000;
   localparam int          BAR_LOG2 = 12;

   logic        pci_clk;
   logic        reset;
   logic        pci_frame_n;
   logic        pci_irdy_n;
   logic [3:0]  pci_cbe_n;
   logic [31:0] ad_drv;
   logic        ad_en;
   logic        par_drv;
   logic        par_en;
   logic        wb_int;
   logic [31:0] wbm_dat_i;
   logic        wbm_ack, wbm_err, wbm_rty;
   wire  [31:0] pci_ad;
   wire         pci_par;
   wire         pci_devsel_n, pci_trdy_n, pci_stop_n, pci_perr_n, pci_inta_n;
   wire  [31:0] wbm_adr, wbm_dat_o;
   wire  [3:0]  wbm_sel;
   wire         wbm_we, wbm_cyc, wbm_stb;
   logic [31:0] mem [0:1023];
   logic        rty_once;
   integer      seed = 59;
   int          timeouts;
   int          errors;
   int          wait_n;
   logic [31:0] addr;
   logic [31:0] data;

   assign pci_ad  = ad_en  ? ad_drv  : 'z;
   assign pci_par = par_en ? par_drv : 1'bz;

   genvar g;
   for (g = 0; g < 32; g++) begin : ad_pull
      pullup (pci_ad[g]);
   end
   pullup (pci_par);
   pullup (pci_devsel_n);
   pullup (pci_trdy_n);
   pullup (pci_stop_n);
   pullup (pci_perr_n);
   pullup (pci_inta_n);

   pci_wb_bridge #(.BAR_BASE(BAR), .BAR_SIZE_LOG2(BAR_LOG2)) pci_wb_bridge_inst (
      .pci_clk_i(pci_clk), .reset_i(reset), .pci_frame_n_i(pci_frame_n),
      .pci_irdy_n_i(pci_irdy_n), .pci_cbe_n_i(pci_cbe_n), .pci_ad_io(pci_ad),
      .pci_par_io(pci_par), .pci_devsel_n_o(pci_devsel_n), .pci_trdy_n_o(pci_trdy_n),
      .pci_stop_n_o(pci_stop_n), .pci_perr_n_o(pci_perr_n), .pci_inta_n_o(pci_inta_n),
      .wb_int_i(wb_int), .wbm_adr_o(wbm_adr), .wbm_dat_o(wbm_dat_o), .wbm_sel_o(wbm_sel),
      .wbm_we_o(wbm_we), .wbm_cyc_o(wbm_cyc), .wbm_stb_o(wbm_stb), .wbm_dat_i(wbm_dat_i),
      .wbm_ack_i(wbm_ack), .wbm_err_i(wbm_err), .wbm_rty_i(wbm_rty)
   );

   bridge_checker #(.BAR_BASE(BAR), .BAR_SIZE_LOG2(BAR_LOG2)) bridge_checker_inst (
      .pci_clk_i(pci_clk), .reset_i(reset), .pci_frame_n_i(pci_frame_n),
      .pci_cbe_n_i(pci_cbe_n), .pci_ad_i(pci_ad),
      .pci_par_i(pci_par), .pci_devsel_n_i(pci_devsel_n), .pci_trdy_n_i(pci_trdy_n),
      .pci_stop_n_i(pci_stop_n), .pci_perr_n_i(pci_perr_n), .pci_inta_n_i(pci_inta_n),
      .wb_int_i(wb_int), .wbm_adr_i(wbm_adr), .wbm_wdat_i(wbm_dat_o), .wbm_sel_i(wbm_sel),
      .wbm_we_i(wbm_we), .wbm_cyc_i(wbm_cyc), .wbm_stb_i(wbm_stb), .wbm_ack_i(wbm_ack),
      .wbm_err_i(wbm_err), .wbm_rty_i(wbm_rty), .errors_o(errors)
   );

   always #5 pci_clk = ~pci_clk;

   // wishbone slave memory with 0 to 3 wait states.
   always begin
      @(posedge pci_clk);
      if (!reset && wbm_cyc && wbm_stb) begin
         wait_n = $random(seed) & 3;
         repeat (wait_n) @(posedge pci_clk);
         #1;
         if (wbm_adr[11]) begin
            wbm_err = 1;
         end else if (rty_once) begin
            wbm_rty = 1;
            rty_once = 0;
         end else begin
            wbm_ack = 1;
            wbm_dat_i = mem[wbm_adr[11:2]];
            for (int b = 0; b < 4; b++) begin
               if (wbm_we && wbm_sel[b]) mem[wbm_adr[11:2]][8*b +: 8] = wbm_dat_o[8*b +: 8];
            end
         end
         @(posedge pci_clk);
         #1;
         wbm_ack = 0;
         wbm_err = 0;
         wbm_rty = 0;
      end
   end

   // one single data phase access; bad_par flips the write PAR.
   task automatic run_pci_access(input logic [31:0] a, input logic [3:0] cmd,
                                 input logic [3:0] be, input logic [31:0] d, input logic bad_par);
      int   n;
      logic ended;
      logic par_on;
      n = 0;
      ended = 0;
      par_on = 0;
      pci_frame_n = 0;
      ad_drv = a;
      ad_en = 1;
      pci_cbe_n = cmd;
      @(posedge pci_clk);
      #1;
      pci_frame_n = 1;
      pci_irdy_n = 0;
      pci_cbe_n = be;
      ad_drv = d;
      ad_en = (cmd == CMD_MEM_WRITE);
      while (!ended) begin
         @(posedge pci_clk);
         n++;
         if (pci_trdy_n === 1'b0 || pci_stop_n === 1'b0) begin
            ended = 1;
         end else if (n >= 6 && pci_devsel_n !== 1'b0) begin
            ended = 1;                                 // master abort.
         end else if (n >= 40) begin
            timeouts++;
            $display("timeout: target gave no TRDY# or STOP# at %0t", $time);
            ended = 1;
         end
         #1;
         if (!ended && ad_en && !par_on) begin
            par_drv = ^{d, be} ^ bad_par;
            par_en = 1;
            par_on = 1;
         end
      end
      pci_irdy_n = 1;
      ad_en = 0;
      pci_cbe_n = 4'hF;
      if (par_on) begin
         @(posedge pci_clk);
         #1;
         par_en = 0;
      end
      repeat (2) @(posedge pci_clk);
      #1;
   endtask

   initial begin
      for (int i = 0; i < 1024; i++) begin
         mem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0203);
      end
      pci_clk = 0;
      reset = 1;
      pci_frame_n = 1;
      pci_irdy_n = 1;
      pci_cbe_n = 4'hF;
      ad_drv = 0;
      ad_en = 0;
      par_drv = 0;
      par_en = 0;
      wb_int = 0;
      wbm_dat_i = 0;
      wbm_ack = 0;
      wbm_err = 0;
      wbm_rty = 0;
      rty_once = 0;
      timeouts = 0;
      repeat (3) @(posedge pci_clk);
      #1;
      reset = 0;
      repeat (3) @(posedge pci_clk);
      #1;
      for (int k = 0; k < 8; k++) begin
         addr = BAR + ($random(seed) & 32'h7FC);
         data = $random(seed);
         run_pci_access(addr, CMD_MEM_WRITE, 4'($random(seed)), data, 0);
         run_pci_access(addr, CMD_MEM_READ, 4'h0, 0, 0);
      end
      run_pci_access(BAR + 32'h10, CMD_MEM_WRITE, 4'h0, 32'hCAFE_0001, 1);
      run_pci_access(BAR + 32'h14, CMD_MEM_WRITE, 4'h0, 32'hCAFE_0002, 0);
      run_pci_access(32'h1000_0040, CMD_MEM_READ, 4'h0, 0, 0);       // outside the BAR.
      run_pci_access(BAR + 32'h20, 4'h2, 4'h0, 0, 0);                // I/O read.
      run_pci_access(BAR + 32'h800, CMD_MEM_WRITE, 4'h0, 32'hDEAD_BEEF, 0);
      run_pci_access(BAR + 32'h804, CMD_MEM_READ, 4'h0, 0, 0);
      rty_once = 1;
      run_pci_access(BAR + 32'h14, CMD_MEM_READ, 4'h0, 0, 0);
      run_pci_access(BAR + 32'h14, CMD_MEM_READ, 4'h0, 0, 0);
      wb_int = 1;
      repeat (3) @(posedge pci_clk);
      #1;
      wb_int = 0;
      repeat (5) @(posedge pci_clk);
      #1;
      $display("checker errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   initial begin
      #200us;
      $display("simulation did not finish in time");
      $display("TESTS FAILED");
      $finish;
   end

endmodule

// File: verilog/pci_pad_ring.sv
// ========================================
// pin level of the bridge. samples the pci inputs
// and drives the shared pins through tristate enables.
// ========================================
`timescale 1ns/10ps

module pci_pad_ring (
   input  logic                        pci_clk_i,
   input  logic                        reset_i,
   input  logic                        pci_frame_n_i,
   input  logic                        pci_irdy_n_i,
   input  logic [pci_pkg::CBE_W-1:0]   pci_cbe_n_i,
   input  logic                        wb_int_i,
   input  logic                        devsel_i,
   input  logic                        trdy_i,
   input  logic                        stop_i,
   input  logic [pci_pkg::AD_W-1:0]    ad_out_i,
   input  logic                        ad_oe_i,
   input  logic                        par_out_i,
   input  logic                        par_oe_i,
   input  logic                        perr_i,
   inout  wire  [pci_pkg::AD_W-1:0]    pci_ad_io,
   inout  wire                         pci_par_io,
   output wire                         pci_devsel_n_o,
   output wire                         pci_trdy_n_o,
   output wire                         pci_stop_n_o,
   output wire                         pci_perr_n_o,
   output wire                         pci_inta_n_o,
   output logic                        frame_o,
   output logic                        irdy_o,
   output logic [pci_pkg::CBE_W-1:0]   cbe_o,
   output logic [pci_pkg::AD_W-1:0]    ad_o,
   output logic                        par_o
);

   logic ctl_hold;                              // one extra cycle driven high.
   logic ctl_oe;
   logic perr_hold;
   logic perr_oe;

   assign ctl_oe  = devsel_i | trdy_i | stop_i | ctl_hold;
   assign perr_oe = perr_i | perr_hold;

   always_ff @(posedge pci_clk_i) begin
      if (reset_i) begin
         frame_o   <= 1'b0;
         irdy_o    <= 1'b0;
         ctl_hold  <= 1'b0;
         perr_hold <= 1'b0;
      end else begin
         frame_o   <= ~pci_frame_n_i;
         irdy_o    <= ~pci_irdy_n_i;
         ctl_hold  <= devsel_i | trdy_i | stop_i;
         perr_hold <= perr_i;
      end
   end

   // C/BE# stays raw, the command decode and parity want pin values.
   always_ff @(posedge pci_clk_i) begin
      cbe_o <= pci_cbe_n_i;
      ad_o  <= pci_ad_io;
      par_o <= pci_par_io;
   end

   assign pci_devsel_n_o = ctl_oe  ? ~devsel_i : 1'bz;
   assign pci_trdy_n_o   = ctl_oe  ? ~trdy_i   : 1'bz;
   assign pci_stop_n_o   = ctl_oe  ? ~stop_i   : 1'bz;
   assign pci_perr_n_o   = perr_oe ? ~perr_i   : 1'bz;

   assign pci_ad_io  = ad_oe_i  ? ad_out_i  : 'z;
   assign pci_par_io = par_oe_i ? par_out_i : 1'bz;

   assign pci_inta_n_o = wb_int_i ? 1'b0 : 1'bz;   // open drain.

endmodule

// File: verilog/pci_parity.sv
// ========================================
// PAR generation for target driven AD cycles and
// parity check of write data with PERR# request.
// ========================================
`timescale 1ns/10ps

module pci_parity (
   input  logic                        pci_clk_i,
   input  logic                        reset_i,
   input  logic [pci_pkg::AD_W-1:0]    ad_out_i,
   input  logic                        ad_oe_i,
   input  logic [pci_pkg::CBE_W-1:0]   cbe_i,
   input  logic [pci_pkg::AD_W-1:0]    ad_i,
   input  logic                        par_i,
   input  logic                        data_wr_done_i,
   output logic                        par_out_o,
   output logic                        par_oe_o,
   output logic                        perr_o
);

   logic par_calc;                              // expected PAR of the write data.
   logic chk_d1;
   logic chk_d2;

   always_ff @(posedge pci_clk_i) begin
      if (reset_i) begin
         par_oe_o <= 1'b0;
         chk_d1   <= 1'b0;
         chk_d2   <= 1'b0;
         perr_o   <= 1'b0;
      end else begin
         par_oe_o <= ad_oe_i;                     // PAR trails AD by one clock.
         chk_d1   <= data_wr_done_i;
         chk_d2   <= chk_d1;
         perr_o   <= chk_d2 & (par_i != par_calc);
      end
   end

   always_ff @(posedge pci_clk_i) begin
      par_out_o <= ^{ad_out_i, cbe_i};
      if (data_wr_done_i) begin
         par_calc <= ^{ad_i, cbe_i};
      end
   end

endmodule

// File: verilog/pci_pkg.sv
// ========================================
// bus widths and enums shared by the bridge.
// ========================================
package pci_pkg;

   localparam int AD_W  = 32;                  // AD bus width.
   localparam int CBE_W = 4;                   // C/BE# bus width.

   // bus commands as they appear on C/BE# in the address phase.
   // anything else is left unclaimed.
   typedef enum logic [3:0] {
      CMD_MEM_READ  = 4'h6,
      CMD_MEM_WRITE = 4'h7
   } pci_cmd_e;

   // target FSM states.
   typedef enum logic [2:0] {
      TGT_IDLE,
      TGT_DECODE,
      TGT_WAIT_IRDY,
      TGT_WB,
      TGT_DATA,
      TGT_TURN
   } tgt_state_e;

   // how a wishbone cycle ended.
   typedef enum logic [1:0] {
      WB_NONE,
      WB_ACK,
      WB_ERR,
      WB_RTY
   } wb_resp_e;

endpackage

// File: verilog/pci_target_fsm.sv
// ========================================
// single data phase pci target. decodes the BAR and
// turns each claimed access into one wishbone request.
// ========================================
`timescale 1ns/10ps

module pci_target_fsm #(
   parameter logic [pci_pkg::AD_W-1:0] BAR_BASE      = 32'h8000_0000,
   parameter int                       BAR_SIZE_LOG2 = 12
) (
   input  logic                        pci_clk_i,
   input  logic                        reset_i,
   input  logic                        frame_i,
   input  logic                        irdy_i,
   input  logic [pci_pkg::CBE_W-1:0]   cbe_i,
   input  logic [pci_pkg::AD_W-1:0]    ad_i,
   input  pci_pkg::wb_resp_e           wb_resp_i,
   input  logic [pci_pkg::AD_W-1:0]    wb_rdata_i,
   output logic                        devsel_o,
   output logic                        trdy_o,
   output logic                        stop_o,
   output logic [pci_pkg::AD_W-1:0]    ad_out_o,
   output logic                        ad_oe_o,
   output logic                        wb_start_o,
   output logic [pci_pkg::AD_W-1:0]    wb_adr_o,
   output logic                        wb_we_o,
   output logic [pci_pkg::CBE_W-1:0]   wb_sel_o,
   output logic [pci_pkg::AD_W-1:0]    wb_wdata_o,
   output logic                        data_wr_done_o
);
   import pci_pkg::*;

   tgt_state_e      state;
   pci_cmd_e        cmd_r;
   logic [AD_W-1:0] addr_r;
   logic            frame_d;
   logic            addr_phase;
   logic            bar_hit;
   logic            cmd_ok;

   assign addr_phase = frame_i & ~frame_d;    // first cycle of FRAME#.
   assign bar_hit    = addr_r[AD_W-1:BAR_SIZE_LOG2] == BAR_BASE[AD_W-1:BAR_SIZE_LOG2];
   assign cmd_ok     = (cmd_r == CMD_MEM_READ) || (cmd_r == CMD_MEM_WRITE);

   assign wb_adr_o = addr_r;
   assign wb_we_o  = (cmd_r == CMD_MEM_WRITE);

   always_ff @(posedge pci_clk_i) begin
      if (reset_i) begin
         state          <= TGT_IDLE;
         frame_d        <= 1'b0;
         devsel_o       <= 1'b0;
         trdy_o         <= 1'b0;
         stop_o         <= 1'b0;
         ad_oe_o        <= 1'b0;
         wb_start_o     <= 1'b0;
         data_wr_done_o <= 1'b0;
      end else begin
         frame_d        <= frame_i;
         wb_start_o     <= 1'b0;
         data_wr_done_o <= 1'b0;
         case (state)
            TGT_IDLE: begin
               if (addr_phase) begin
                  state <= TGT_DECODE;
               end
            end
            TGT_DECODE: begin
               if (bar_hit && cmd_ok) begin
                  devsel_o <= 1'b1;                 // medium decode.
                  if (wb_we_o) begin
                     state <= TGT_WAIT_IRDY;
                  end else begin
                     wb_start_o <= 1'b1;
                     state      <= TGT_WB;
                  end
               end else begin
                  state <= TGT_IDLE;                 // master abort.
               end
            end
            TGT_WAIT_IRDY: begin
               if (irdy_i) begin
                  wb_start_o <= 1'b1;
                  state      <= TGT_WB;
               end
            end
            TGT_WB: begin
               case (wb_resp_i)
                  WB_ACK: begin
                     trdy_o         <= 1'b1;
                     stop_o         <= frame_i;   // disconnect with data.
                     ad_oe_o        <= ~wb_we_o;
                     data_wr_done_o <= wb_we_o;
                     state          <= TGT_DATA;
                  end
                  WB_RTY: begin
                     stop_o <= 1'b1;
                     state  <= TGT_DATA;
                  end
                  WB_ERR: begin
                     stop_o   <= 1'b1;              // target abort.
                     devsel_o <= 1'b0;
                     state    <= TGT_DATA;
                  end
                  default: begin
                     state <= TGT_WB;
                  end
               endcase
            end
            TGT_DATA: begin
               devsel_o <= 1'b0;
               trdy_o   <= 1'b0;
               stop_o   <= 1'b0;
               ad_oe_o  <= 1'b0;
               state    <= TGT_TURN;
            end
            TGT_TURN: begin
               state <= TGT_IDLE;
            end
            default: begin
               state <= TGT_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge pci_clk_i) begin
      if (state == TGT_IDLE && addr_phase) begin
         addr_r <= ad_i;
         cmd_r  <= pci_cmd_e'(cbe_i);
      end
      if (state == TGT_DECODE) begin
         wb_sel_o <= ~cbe_i;                        // read byte enables.
      end
      if (state == TGT_WAIT_IRDY && irdy_i) begin
         wb_sel_o   <= ~cbe_i;
         wb_wdata_o <= ad_i;
      end
      if (state == TGT_WB && wb_resp_i == WB_ACK) begin
         ad_out_o <= wb_rdata_i;
      end
   end

endmodule

// File: verilog/pci_wb_bridge.sv
// ========================================
// pci target to wishbone master bridge, top level.
// ========================================
`timescale 1ns/10ps

module pci_wb_bridge #(
   parameter logic [pci_pkg::AD_W-1:0] BAR_BASE      = 32'h8000_0000,
   parameter int                       BAR_SIZE_LOG2 = 12
) (
   input  logic                        pci_clk_i,
   input  logic                        reset_i,
   input  logic                        pci_frame_n_i,
   input  logic                        pci_irdy_n_i,
   input  logic [pci_pkg::CBE_W-1:0]   pci_cbe_n_i,
   inout  wire  [pci_pkg::AD_W-1:0]    pci_ad_io,
   inout  wire                         pci_par_io,
   output wire                         pci_devsel_n_o,
   output wire                         pci_trdy_n_o,
   output wire                         pci_stop_n_o,
   output wire                         pci_perr_n_o,
   output wire                         pci_inta_n_o,
   input  logic                        wb_int_i,
   output logic [pci_pkg::AD_W-1:0]    wbm_adr_o,
   output logic [pci_pkg::AD_W-1:0]    wbm_dat_o,
   output logic [pci_pkg::CBE_W-1:0]   wbm_sel_o,
   output logic                        wbm_we_o,
   output logic                        wbm_cyc_o,
   output logic                        wbm_stb_o,
   input  logic [pci_pkg::AD_W-1:0]    wbm_dat_i,
   input  logic                        wbm_ack_i,
   input  logic                        wbm_err_i,
   input  logic                        wbm_rty_i
);
   import pci_pkg::*;

   logic             frame_q;
   logic             irdy_q;
   logic [CBE_W-1:0] cbe_q;
   logic [AD_W-1:0]  ad_q;
   logic             par_q;
   logic             devsel;
   logic             trdy;
   logic             stop;
   logic [AD_W-1:0]  ad_out;
   logic             ad_oe;
   logic             par_out;
   logic             par_oe;
   logic             perr;
   logic             data_wr_done;
   logic             wb_start;
   logic [AD_W-1:0]  wb_adr;
   logic             wb_we;
   logic [CBE_W-1:0] wb_sel;
   logic [AD_W-1:0]  wb_wdata;
   logic [AD_W-1:0]  wb_rdata;
   wb_resp_e         wb_resp;

   pci_pad_ring pci_pad_ring_inst (
      .pci_clk_i     (pci_clk_i),
      .reset_i       (reset_i),
      .pci_frame_n_i (pci_frame_n_i),
      .pci_irdy_n_i  (pci_irdy_n_i),
      .pci_cbe_n_i   (pci_cbe_n_i),
      .wb_int_i      (wb_int_i),
      .devsel_i      (devsel),
      .trdy_i        (trdy),
      .stop_i        (stop),
      .ad_out_i      (ad_out),
      .ad_oe_i       (ad_oe),
      .par_out_i     (par_out),
      .par_oe_i      (par_oe),
      .perr_i        (perr),
      .pci_ad_io     (pci_ad_io),
      .pci_par_io    (pci_par_io),
      .pci_devsel_n_o(pci_devsel_n_o),
      .pci_trdy_n_o  (pci_trdy_n_o),
      .pci_stop_n_o  (pci_stop_n_o),
      .pci_perr_n_o  (pci_perr_n_o),
      .pci_inta_n_o  (pci_inta_n_o),
      .frame_o       (frame_q),
      .irdy_o        (irdy_q),
      .cbe_o         (cbe_q),
      .ad_o          (ad_q),
      .par_o         (par_q)
   );

   pci_target_fsm #(
      .BAR_BASE     (BAR_BASE),
      .BAR_SIZE_LOG2(BAR_SIZE_LOG2)
   ) pci_target_fsm_inst (
      .pci_clk_i     (pci_clk_i),
      .reset_i       (reset_i),
      .frame_i       (frame_q),
      .irdy_i        (irdy_q),
      .cbe_i         (cbe_q),
      .ad_i          (ad_q),
      .wb_resp_i     (wb_resp),
      .wb_rdata_i    (wb_rdata),
      .devsel_o      (devsel),
      .trdy_o        (trdy),
      .stop_o        (stop),
      .ad_out_o      (ad_out),
      .ad_oe_o       (ad_oe),
      .wb_start_o    (wb_start),
      .wb_adr_o      (wb_adr),
      .wb_we_o       (wb_we),
      .wb_sel_o      (wb_sel),
      .wb_wdata_o    (wb_wdata),
      .data_wr_done_o(data_wr_done)
   );

   pci_parity pci_parity_inst (
      .pci_clk_i     (pci_clk_i),
      .reset_i       (reset_i),
      .ad_out_i      (ad_out),
      .ad_oe_i       (ad_oe),
      .cbe_i         (cbe_q),
      .ad_i          (ad_q),
      .par_i         (par_q),
      .data_wr_done_i(data_wr_done),
      .par_out_o     (par_out),
      .par_oe_o      (par_oe),
      .perr_o        (perr)
   );

   wb_master_port wb_master_port_inst (
      .pci_clk_i(pci_clk_i),
      .reset_i  (reset_i),
      .start_i  (wb_start),
      .adr_i    (wb_adr),
      .we_i     (wb_we),
      .sel_i    (wb_sel),
      .wdata_i  (wb_wdata),
      .wbm_dat_i(wbm_dat_i),
      .wbm_ack_i(wbm_ack_i),
      .wbm_err_i(wbm_err_i),
      .wbm_rty_i(wbm_rty_i),
      .wbm_adr_o(wbm_adr_o),
      .wbm_dat_o(wbm_dat_o),
      .wbm_sel_o(wbm_sel_o),
      .wbm_we_o (wbm_we_o),
      .wbm_cyc_o(wbm_cyc_o),
      .wbm_stb_o(wbm_stb_o),
      .resp_o   (wb_resp),
      .rdata_o  (wb_rdata)
   );

endmodule

// File: verilog/wb_master_port.sv
// ========================================
// wishbone master side. one cycle per start strobe,
// one classified response back to the target FSM.
// ========================================
`timescale 1ns/10ps

module wb_master_port (
   input  logic                        pci_clk_i,
   input  logic                        reset_i,
   input  logic                        start_i,
   input  logic [pci_pkg::AD_W-1:0]    adr_i,
   input  logic                        we_i,
   input  logic [pci_pkg::CBE_W-1:0]   sel_i,
   input  logic [pci_pkg::AD_W-1:0]    wdata_i,
   input  logic [pci_pkg::AD_W-1:0]    wbm_dat_i,
   input  logic                        wbm_ack_i,
   input  logic                        wbm_err_i,
   input  logic                        wbm_rty_i,
   output logic [pci_pkg::AD_W-1:0]    wbm_adr_o,
   output logic [pci_pkg::AD_W-1:0]    wbm_dat_o,
   output logic [pci_pkg::CBE_W-1:0]   wbm_sel_o,
   output logic                        wbm_we_o,
   output logic                        wbm_cyc_o,
   output logic                        wbm_stb_o,
   output pci_pkg::wb_resp_e           resp_o,
   output logic [pci_pkg::AD_W-1:0]    rdata_o
);
   import pci_pkg::*;

   logic cyc_r;
   logic term;

   assign term      = cyc_r & (wbm_ack_i | wbm_err_i | wbm_rty_i);
   assign wbm_cyc_o = cyc_r;
   assign wbm_stb_o = cyc_r;                     // no bursts, stb follows cyc.

   always_ff @(posedge pci_clk_i) begin
      if (reset_i) begin
         cyc_r  <= 1'b0;
         resp_o <= WB_NONE;
      end else begin
         resp_o <= WB_NONE;
         if (start_i) begin
            cyc_r <= 1'b1;
         end else if (term) begin
            cyc_r <= 1'b0;
            // err wins over rty, rty over ack.
            if (wbm_err_i) begin
               resp_o <= WB_ERR;
            end else if (wbm_rty_i) begin
               resp_o <= WB_RTY;
            end else begin
               resp_o <= WB_ACK;
            end
         end
      end
   end

   always_ff @(posedge pci_clk_i) begin
      if (start_i) begin
         wbm_adr_o <= adr_i;
         wbm_dat_o <= wdata_i;
         wbm_sel_o <= sel_i;
         wbm_we_o  <= we_i;
      end
      if (cyc_r && wbm_ack_i) begin
         rdata_o <= wbm_dat_i;
      end
   end

endmodule
